/* Makefile */
TOP = tb_alignment_buffer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -f flist.f \
		--top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf obj_dir

/* align/align_fsm.sv */
// Halfword alignment tracker
`timescale 1ns/100ps

module align_fsm import albuf_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        pc_set_i,
  // Bit 1 of the branch target
  input  logic        branch_half_i,
  input  logic        resp_push_i,
  input  fetch_word_u resp_word_i,
  output logic [1:0]  n_incoming_o
);

  align_state_e state_q;
  align_state_e state_n;

  // Low bits of 2'b11 mark a 32-bit instruction
  logic lo_uncompressed;
  logic hi_uncompressed;

  assign lo_uncompressed = resp_word_i.half.lo[1:0] == 2'b11;
  assign hi_uncompressed = resp_word_i.half.hi[1:0] == 2'b11;

  always_comb begin
    state_n      = state_q;
    n_incoming_o = 2'd0;
    if (pc_set_i) begin
      // Target halfword decides where the first word starts
      state_n = branch_half_i ? UNALIGNED_SKIP : ALIGNED;
    end else if (resp_push_i) begin
      case (state_q)
        ALIGNED: begin
          if (lo_uncompressed) begin
            // One full 32-bit instruction
            n_incoming_o = 2'd1;
          end else if (hi_uncompressed) begin
            // Compressed low, upper half starts a split instruction
            n_incoming_o = 2'd1;
            state_n      = UNALIGNED_SPLIT;
          end else begin
            n_incoming_o = 2'd2;
          end
        end
        UNALIGNED_SKIP: begin
          // Lower half is not part of the stream
          if (hi_uncompressed) begin
            state_n = UNALIGNED_SPLIT;
          end else begin
            n_incoming_o = 2'd1;
            state_n      = ALIGNED;
          end
        end
        UNALIGNED_SPLIT: begin
          // Lower half completes the pending instruction
          if (hi_uncompressed) begin
            n_incoming_o = 2'd1;
          end else begin
            n_incoming_o = 2'd2;
            state_n      = ALIGNED;
          end
        end
        default: begin
          state_n = ALIGNED;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALIGNED;
    end else begin
      state_q <= state_n;
    end
  end

endmodule

/* align/instr_aligner.sv */
// Instruction output aligner
`timescale 1ns/100ps
`include "albuf_settings.svh"

module instr_aligner import albuf_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     pc_set_i,
  input  logic                     kill_if_i,
  input  logic [`ALBUF_ADDR_W-1:0] branch_addr_i,
  input  logic                     instr_ready_i,

  // Incoming response, used when the FIFO runs dry
  input  logic                     resp_push_i,
  input  fetch_word_u              resp_word_i,
  input  logic                     resp_err_i,

  // FIFO head and the entry after it
  input  fetch_word_u              head_word_i,
  input  fetch_word_u              next_word_i,
  input  logic                     head_err_i,
  input  logic                     next_err_i,
  input  logic                     head_valid_i,
  input  logic                     next_valid_i,

  // Decode side
  output logic                     instr_valid_o,
  output fetch_word_u              instr_rdata_o,
  output logic                     instr_err_o,
  output logic [`ALBUF_ADDR_W-1:0] instr_addr_o,

  output logic                     pop_word_o,
  output logic                     instr_pop_o
);

  localparam int AW = `ALBUF_ADDR_W;

  logic [AW-1:0] addr_q;
  logic [AW-1:0] addr_n;
  logic [AW-1:0] addr_incr;

  // Source word for the current instruction
  fetch_word_u   word_al;
  fetch_word_u   word_unal;
  logic [15:0]   second_lo;
  logic          err_al;
  logic          err_second;
  logic          err_unal;

  logic          avail;
  logic          avail_split;
  logic          al_compressed;
  logic          unal_compressed;
  logic          consume;

  // Head entry first, else the word arriving this cycle
  assign word_al    = head_valid_i ? head_word_i : resp_word_i;
  assign err_al     = head_valid_i ? head_err_i  : resp_err_i;

  // Lower half of the following word for straddling instructions
  assign second_lo  = next_valid_i ? next_word_i.half.lo : resp_word_i.half.lo;
  assign err_second = next_valid_i ? next_err_i : resp_err_i;

  assign word_unal.half.hi = second_lo;
  assign word_unal.half.lo = word_al.half.hi;

  assign al_compressed   = word_al.half.lo[1:0] != 2'b11;
  assign unal_compressed = word_al.half.hi[1:0] != 2'b11;

  // A straddling 32-bit instruction takes faults from both words
  assign err_unal = err_al | (head_valid_i & ~unal_compressed & err_second);

  // Something to show at all, and both halves for a straddling one
  assign avail       = head_valid_i | resp_push_i;
  assign avail_split = next_valid_i | (head_valid_i & resp_push_i);

  always_comb begin
    instr_rdata_o = word_al;
    instr_err_o   = err_al;
    instr_valid_o = 1'b0;
    if (kill_if_i) begin
      // Nothing leaves while the stage is killed
      instr_valid_o = 1'b0;
    end else if (addr_q[1]) begin
      instr_rdata_o = word_unal;
      instr_err_o   = err_unal;
      instr_valid_o = avail & (unal_compressed | avail_split);
    end else begin
      instr_valid_o = avail;
    end
  end

  assign consume     = instr_valid_o & instr_ready_i;
  assign instr_pop_o = consume;

  //////////////////////////////////////////////////////////////////////
  // Next address and word release
  //////////////////////////////////////////////////////////////////////

  assign addr_incr = {addr_q[AW-1:2], 2'b00} + AW'(4);

  always_comb begin
    addr_n     = addr_q;
    pop_word_o = 1'b0;
    if (addr_q[1]) begin
      // Upper half consumed, head word is done either way
      addr_n     = unal_compressed ? addr_incr : {addr_incr[AW-1:2], 2'b10};
      pop_word_o = consume;
    end else if (al_compressed) begin
      // Upper half of head still pending
      addr_n = {addr_q[AW-1:2], 2'b10};
    end else begin
      addr_n     = addr_incr;
      pop_word_o = consume;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (pc_set_i) begin
      // First instruction after the branch sits at the target
      addr_q <= branch_addr_i;
    end else if (consume) begin
      addr_q <= addr_n;
    end
  end

  assign instr_addr_o = addr_q;

endmodule

/* common/albuf_pkg.sv */
// Alignment buffer types
package albuf_pkg;

  // Two halfwords of one fetched word
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } fetch_half_t;

  // Fetch word as a plain word or as two halfwords
  typedef union packed {
    logic [31:0] word;
    fetch_half_t half;
  } fetch_word_u;

  // Halfword alignment of the next word written into the buffer
  typedef enum logic [1:0] {
    // Next instruction starts at bit 0
    ALIGNED         = 2'd0,
    // Branch to an odd halfword, drop the lower half
    UNALIGNED_SKIP  = 2'd1,
    // Lower half ends an instruction begun in the previous word
    UNALIGNED_SPLIT = 2'd2
  } align_state_e;

endpackage

/* common/albuf_settings.svh */
// Alignment buffer settings
`ifndef ALBUF_SETTINGS_SVH
`define ALBUF_SETTINGS_SVH

// Number of 32-bit word entries in the FIFO
`define ALBUF_DEPTH 3

// Width of the FIFO pointers and the outstanding counter
`define ALBUF_CNT_W 2

// Instruction address width
`define ALBUF_ADDR_W 32

// Highest number of fetches in flight
`define ALBUF_MAX_OUTSTND 2

`endif

/* fetch/fetch_counters.sv */
// Fetch and instruction counters
`timescale 1ns/100ps
`include "albuf_settings.svh"

module fetch_counters (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    instr_req_i,
  input  logic                    pc_set_i,
  input  logic                    kill_if_i,
  input  logic                    fetch_ready_i,
  input  logic                    resp_valid_i,
  // Instructions completed by the pushed word
  input  logic [1:0]              n_incoming_i,
  input  logic                    instr_pop_i,
  output logic                    fetch_valid_o,
  output logic                    resp_push_o,
  output logic                    prefetch_busy_o,
  output logic [`ALBUF_CNT_W-1:0] outstnd_cnt_o
);

  localparam int CW  = `ALBUF_CNT_W;
  // Room for two instructions per buffered word
  localparam int ICW = `ALBUF_CNT_W + 1;

  logic [CW-1:0]  outstnd_q;
  logic [CW-1:0]  outstnd_n;
  logic [CW-1:0]  flush_q;
  logic [CW-1:0]  flush_n;
  logic [ICW-1:0] instr_cnt_q;
  logic [ICW-1:0] instr_cnt_n;
  // Instruction taken last cycle
  logic           pop_q;
  logic [ICW-1:0] instr_avail;
  logic           count_up;

  // Responses for fetches issued before a branch are dropped
  assign resp_push_o = (flush_q != '0) ? 1'b0 : resp_valid_i;

  assign instr_avail = instr_cnt_q - ICW'(pop_q);

  // Refill when nearly empty, always on a branch
  assign fetch_valid_o = instr_req_i &&
                         (outstnd_q < CW'(`ALBUF_MAX_OUTSTND)) &&
                         ((instr_avail == '0) ||
                          ((instr_avail == ICW'(1)) && (outstnd_q == '0)) ||
                          pc_set_i);

  assign prefetch_busy_o = (outstnd_q != '0) || fetch_valid_o;
  assign count_up        = fetch_valid_o && fetch_ready_i;

  always_comb begin
    outstnd_n = outstnd_q;
    case ({count_up, resp_valid_i})
      2'b10:   outstnd_n = outstnd_q + CW'(1);
      2'b01:   outstnd_n = outstnd_q - CW'(1);
      default: outstnd_n = outstnd_q;
    endcase
  end

  // Buffered instruction count, pops subtracted one cycle late
  always_comb begin
    if (kill_if_i) begin
      instr_cnt_n = '0;
    end else begin
      instr_cnt_n = instr_cnt_q + ICW'(n_incoming_i) - ICW'(pop_q);
    end
  end

  always_comb begin
    flush_n = flush_q;
    if (pc_set_i) begin
      // A response arriving now under kill is already gone
      if (kill_if_i && resp_valid_i) begin
        flush_n = outstnd_q - CW'(1);
      end else begin
        flush_n = outstnd_q;
      end
    end else if (resp_valid_i && (flush_q != '0)) begin
      flush_n = flush_q - CW'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstnd_q   <= '0;
      flush_q     <= '0;
      instr_cnt_q <= '0;
      pop_q       <= 1'b0;
    end else begin
      outstnd_q   <= outstnd_n;
      flush_q     <= flush_n;
      instr_cnt_q <= instr_cnt_n;
      pop_q       <= instr_pop_i;
    end
  end

  assign outstnd_cnt_o = outstnd_q;

endmodule

/* flist.f */
+incdir+common
common/albuf_pkg.sv
fetch/fetch_counters.sv
align/align_fsm.sv
align/instr_aligner.sv
source/albuf_fifo.sv
source/alignment_buffer.sv
testbench/albuf_props.sv
testbench/tb_alignment_buffer.sv

/* source/albuf_fifo.sv */
// Fetch word FIFO
`timescale 1ns/100ps
`include "albuf_settings.svh"

module albuf_fifo import albuf_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        pc_set_i,
  input  logic        kill_if_i,

  // Write side
  input  logic        push_i,
  input  fetch_word_u push_word_i,
  input  logic        push_err_i,

  // Read side
  input  logic        pop_word_i,
  output fetch_word_u head_word_o,
  output fetch_word_u next_word_o,
  output logic        head_err_o,
  output logic        next_err_o,
  output logic        head_valid_o,
  output logic        next_valid_o
);

  localparam int DEPTH = `ALBUF_DEPTH;
  localparam int CW    = `ALBUF_CNT_W;

  fetch_word_u      word_q [DEPTH];
  logic [DEPTH-1:0] err_q;
  logic [DEPTH-1:0] valid_q;
  logic [DEPTH-1:0] valid_n;

  logic [CW-1:0]    wptr_q;
  logic [CW-1:0]    rptr_q;
  logic [CW-1:0]    wptr_inc;
  logic [CW-1:0]    rptr_inc;
  logic             write_en;

  // Writes are dropped while the stage is killed
  assign write_en = push_i & ~kill_if_i;

  // Pointer increments wrap after the last entry
  assign wptr_inc = (wptr_q == CW'(DEPTH-1)) ? '0 : wptr_q + CW'(1);
  assign rptr_inc = (rptr_q == CW'(DEPTH-1)) ? '0 : rptr_q + CW'(1);

  assign head_word_o  = word_q[rptr_q];
  assign head_err_o   = err_q[rptr_q];
  assign head_valid_o = valid_q[rptr_q];
  assign next_word_o  = word_q[rptr_inc];
  assign next_err_o   = err_q[rptr_inc];
  assign next_valid_o = valid_q[rptr_inc];

  always_comb begin
    valid_n = valid_q;
    if (write_en) begin
      valid_n[wptr_q] = 1'b1;
    end
    // Pass-through word is written and released in the same cycle
    if (pop_word_i) begin
      valid_n[rptr_q] = 1'b0;
    end
    if (kill_if_i) begin
      valid_n = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else begin
      valid_q <= valid_n;
      if (pc_set_i) begin
        // New stream starts at entry zero
        wptr_q <= '0;
        rptr_q <= '0;
      end else begin
        if (write_en) begin
          wptr_q <= wptr_inc;
        end
        if (pop_word_i) begin
          rptr_q <= rptr_inc;
        end
      end
    end
  end

  // Word payload and its error bit
  always_ff @(posedge clk) begin
    if (write_en) begin
      word_q[wptr_q] <= push_word_i;
      err_q[wptr_q]  <= push_err_i;
    end
  end

endmodule

/* source/alignment_buffer.sv */
// Instruction alignment buffer
`timescale 1ns/100ps
`include "albuf_settings.svh"

module alignment_buffer import albuf_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,

  // Decode side controls
  input  logic                     instr_req_i,
  input  logic                     pc_set_i,
  input  logic [`ALBUF_ADDR_W-1:0] branch_addr_i,
  input  logic                     kill_if_i,
  output logic                     prefetch_busy_o,

  // Prefetcher request
  output logic                     fetch_valid_o,
  input  logic                     fetch_ready_i,
  output logic                     fetch_branch_o,
  output logic [`ALBUF_ADDR_W-1:0] fetch_branch_addr_o,

  // Prefetcher response
  input  logic                     resp_valid_i,
  input  fetch_word_u              resp_rdata_i,
  input  logic                     resp_err_i,

  // Instruction output to decode
  output logic                     instr_valid_o,
  input  logic                     instr_ready_i,
  output fetch_word_u              instr_rdata_o,
  output logic                     instr_err_o,
  output logic [`ALBUF_ADDR_W-1:0] instr_addr_o,
  output logic [`ALBUF_CNT_W-1:0]  outstnd_cnt_o
);

  // Response accepted into the buffer
  logic        resp_push;
  // Complete instructions in the pushed word
  logic [1:0]  n_incoming;

  // FIFO read side
  fetch_word_u head_word;
  fetch_word_u next_word;
  logic        head_err;
  logic        next_err;
  logic        head_valid;
  logic        next_valid;

  // Consumption feedback from the aligner
  logic        pop_word;
  logic        instr_pop;

  // Branch goes straight to the prefetcher, word aligned down to a halfword
  assign fetch_branch_o      = pc_set_i;
  assign fetch_branch_addr_o = {branch_addr_i[`ALBUF_ADDR_W-1:1], 1'b0};

  //////////////////////////////////////////////////////////////////////
  // Fetch request and flush control
  //////////////////////////////////////////////////////////////////////

  fetch_counters u_counters (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_req_i     (instr_req_i),
    .pc_set_i        (pc_set_i),
    .kill_if_i       (kill_if_i),
    .fetch_ready_i   (fetch_ready_i),
    .resp_valid_i    (resp_valid_i),
    .n_incoming_i    (n_incoming),
    .instr_pop_i     (instr_pop),
    .fetch_valid_o   (fetch_valid_o),
    .resp_push_o     (resp_push),
    .prefetch_busy_o (prefetch_busy_o),
    .outstnd_cnt_o   (outstnd_cnt_o)
  );

  // Instruction counting per pushed word
  align_fsm u_align_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .branch_half_i (branch_addr_i[1]),
    .resp_push_i   (resp_push),
    .resp_word_i   (resp_rdata_i),
    .n_incoming_o  (n_incoming)
  );

  //////////////////////////////////////////////////////////////////////
  // Word storage and instruction output
  //////////////////////////////////////////////////////////////////////

  albuf_fifo u_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_set_i     (pc_set_i),
    .kill_if_i    (kill_if_i),
    .push_i       (resp_push),
    .push_word_i  (resp_rdata_i),
    .push_err_i   (resp_err_i),
    .pop_word_i   (pop_word),
    .head_word_o  (head_word),
    .next_word_o  (next_word),
    .head_err_o   (head_err),
    .next_err_o   (next_err),
    .head_valid_o (head_valid),
    .next_valid_o (next_valid)
  );

  instr_aligner u_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .kill_if_i     (kill_if_i),
    .branch_addr_i (branch_addr_i),
    .instr_ready_i (instr_ready_i),
    .resp_push_i   (resp_push),
    .resp_word_i   (resp_rdata_i),
    .resp_err_i    (resp_err_i),
    .head_word_i   (head_word),
    .next_word_i   (next_word),
    .head_err_i    (head_err),
    .next_err_i    (next_err),
    .head_valid_i  (head_valid),
    .next_valid_i  (next_valid),
    .instr_valid_o (instr_valid_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_err_o   (instr_err_o),
    .instr_addr_o  (instr_addr_o),
    .pop_word_o    (pop_word),
    .instr_pop_o   (instr_pop)
  );

endmodule

/* testbench/albuf_golden.txt */
// Columns: memory words at 000, error masks at 040, tests at 050 as target kill_cycles ready_pct count
// Expected stream at 080 as address instruction error, one instruction per line
@000
05134505 808200a5 00b50593 46010505
07330789 87b300c7 852240d7 00e68633
05331111 468102b5 87930705 8a050017
87934709 859300a7 450100d5 80820405
// Error word mask, bit n marks memory word n
@040
00002000 00000000
// Test count, then one test per line
@050
00000005
00000000 00000001 00000000 0000000b
00000022 00000001 00000000 00000005
00000010 00000001 00000032 00000005
00000030 00000001 00000000 00000006
00000008 00000004 00000032 00000003
@080
// Aligned stream from zero
00000000 00004505 00000000
00000002 00a50513 00000000
00000006 00008082 00000000
00000008 00b50593 00000000
0000000c 00000505 00000000
0000000e 00004601 00000000
00000010 00000789 00000000
00000012 00c70733 00000000
00000016 40d787b3 00000000
0000001a 00008522 00000000
0000001c 00e68633 00000000
// Branch to an odd halfword
00000022 02b50533 00000000
00000026 00004681 00000000
00000028 00000705 00000000
0000002a 00178793 00000000
0000002e 00008a05 00000000
// Back-pressure
00000010 00000789 00000000
00000012 00c70733 00000000
00000016 40d787b3 00000000
0000001a 00008522 00000000
0000001c 00e68633 00000000
// Error words
00000030 00004709 00000000
00000032 00a78793 00000001
00000036 00d58593 00000001
0000003a 00004501 00000000
0000003c 00000405 00000000
0000003e 00008082 00000000
// Kill then branch
00000008 00b50593 00000000
0000000c 00000505 00000000
0000000e 00004601 00000000

/* testbench/albuf_props.sv */
// Alignment buffer assertions
`timescale 1ns/100ps
`include "albuf_settings.svh"

module albuf_props (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    kill_if_i,
  input logic                    resp_valid_i,
  input logic                    instr_valid_i,
  input logic [`ALBUF_CNT_W-1:0] outstnd_cnt_i
);

  // Never more fetches in flight than the limit
  a_outstnd_max: assert property (@(posedge clk) disable iff (!rst_n)
    outstnd_cnt_i <= `ALBUF_CNT_W'(`ALBUF_MAX_OUTSTND))
    else $error("outstanding count above limit");

  // Nothing leaves while the stage is killed
  a_kill_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    kill_if_i |-> !instr_valid_i)
    else $error("instruction valid during kill");

  // Kill empties the buffer, only a fresh response can be shown after it
  a_kill_empty: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(kill_if_i) && !resp_valid_i) |-> !instr_valid_i)
    else $error("instruction valid from a killed buffer");

endmodule

bind alignment_buffer albuf_props u_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .kill_if_i     (kill_if_i),
  .resp_valid_i  (resp_valid_i),
  .instr_valid_i (instr_valid_o),
  .outstnd_cnt_i (outstnd_cnt_o)
);

/* testbench/tb_alignment_buffer.sv */
// Alignment buffer testbench
`timescale 1ns/100ps

module tb_alignment_buffer import albuf_pkg::*; ();

  // Golden file sections
  localparam int MEM_WORDS = 64;
  localparam int MASK_BASE = 64;
  localparam int TEST_BASE = 80;
  localparam int EXP_BASE  = 128;

  logic        clk;
  logic        rst_n;
  logic        instr_req;
  logic        pc_set;
  logic [31:0] branch_addr;
  logic        kill_if;
  logic        fetch_ready;
  logic        resp_valid;
  fetch_word_u resp_rdata;
  logic        resp_err;
  logic        instr_ready;

  logic        fetch_valid;
  logic        fetch_branch;
  logic [31:0] fetch_branch_addr;
  logic        instr_valid;
  fetch_word_u instr_rdata;
  logic        instr_err;
  logic [31:0] instr_addr;
  logic        prefetch_busy;
  logic [1:0]  outstnd_cnt;

  // Memory image, masks, commands and expected stream
  logic [31:0] gold [0:255];
  logic [63:0] err_mask;

  // Prefetcher model state
  logic [31:0] fetch_addr;
  logic [31:0] pend_addr [$];
  int          pend_due [$];
  int          last_due;
  int          cyc;

  int unsigned lcg_state;
  int          cur_test;
  int          exp_idx;
  int          exp_start;
  int          exp_end;
  int          n_checks;
  int          n_errors;
  int          wd_limit;

  alignment_buffer u_dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .instr_req_i         (instr_req),
    .pc_set_i            (pc_set),
    .branch_addr_i       (branch_addr),
    .kill_if_i           (kill_if),
    .prefetch_busy_o     (prefetch_busy),
    .fetch_valid_o       (fetch_valid),
    .fetch_ready_i       (fetch_ready),
    .fetch_branch_o      (fetch_branch),
    .fetch_branch_addr_o (fetch_branch_addr),
    .resp_valid_i        (resp_valid),
    .resp_rdata_i        (resp_rdata),
    .resp_err_i          (resp_err),
    .instr_valid_o       (instr_valid),
    .instr_ready_i       (instr_ready),
    .instr_rdata_o       (instr_rdata),
    .instr_err_o         (instr_err),
    .instr_addr_o        (instr_addr),
    .outstnd_cnt_o       (outstnd_cnt)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // Words outside the image, different at every address
  function automatic logic [31:0] fill_word(input int idx);
    return (32'(idx) * 32'h0004_0401) ^ 32'h9e37_79b9;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      0:       return "aligned_stream";
      1:       return "odd_branch";
      2:       return "back_pressure";
      3:       return "error_words";
      default: return "kill_branch";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    if (expected !== actual) begin
      n_errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Compressed instructions only carry the low halfword
  task automatic check_instr();
    logic [31:0] e_addr;
    logic [31:0] e_data;
    logic [31:0] e_err;
    logic [31:0] mask;
    string       nm;
    e_addr = gold[EXP_BASE + 3 * exp_idx];
    e_data = gold[EXP_BASE + 3 * exp_idx + 1];
    e_err  = gold[EXP_BASE + 3 * exp_idx + 2];
    mask   = (e_data[1:0] == 2'b11) ? 32'hffff_ffff : 32'h0000_ffff;
    nm     = $sformatf("%s #%0d", test_name(cur_test), exp_idx - exp_start);
    check_value({nm, " addr"}, e_addr, instr_addr);
    check_value({nm, " data"}, e_data & mask, instr_rdata.word & mask);
    check_value({nm, " err"}, e_err, {31'd0, instr_err});
    exp_idx++;
  endtask

  // One clock: drive after the edge, sample at the falling edge
  task automatic step(input logic kill, input logic set, input logic [31:0] target,
                      input int ready_pct);
    logic [31:0] a;
    int          due;
    int          n_out;
    logic        busy_exp;
    string       nm;
    @(posedge clk);
    cyc++;
    #10;
    if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
      a               = pend_addr.pop_front();
      due             = pend_due.pop_front();
      resp_valid      = 1'b1;
      resp_rdata.word = gold[a[7:2]];
      resp_err        = err_mask[a[7:2]];
    end else begin
      resp_valid      = 1'b0;
      resp_rdata.word = 32'd0;
      resp_err        = 1'b0;
    end
    // Fetching is allowed from the first command on
    instr_req   = 1'b1;
    kill_if     = kill;
    pc_set      = set;
    branch_addr = target;
    instr_ready = (ready_pct == 0) ? 1'b1 : (int'(next_rand() % 100) < ready_pct);
    #40;
    nm       = test_name(cur_test);
    // Fetches in flight include the response on the bus this cycle
    n_out    = pend_addr.size() + int'(resp_valid);
    busy_exp = (n_out != 0) || fetch_valid;
    check_value({nm, " outstanding"}, 32'(n_out), {30'd0, outstnd_cnt});
    check_value({nm, " busy"}, {31'd0, busy_exp}, {31'd0, prefetch_busy});
    // Branch word fetch starts at the word holding the target
    if (fetch_branch) begin
      check_value({nm, " branch addr"}, {target[31:1], 1'b0}, fetch_branch_addr);
      fetch_addr = {fetch_branch_addr[31:2], 2'b00};
    end
    if (fetch_valid && fetch_ready) begin
      due = cyc + 1 + int'(next_rand() % 3);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      pend_addr.push_back(fetch_addr);
      pend_due.push_back(due);
      fetch_addr = fetch_addr + 32'd4;
    end
    if (instr_valid && instr_ready) begin
      check_instr();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          n_tests;
    int          total;
    logic [31:0] target;
    int          kills;
    int          pct;
    int          n_exp;
    rst_n           = 1'b0;
    instr_req       = 1'b0;
    pc_set          = 1'b0;
    branch_addr     = 32'd0;
    kill_if         = 1'b0;
    fetch_ready     = 1'b1;
    resp_valid      = 1'b0;
    resp_rdata.word = 32'd0;
    resp_err        = 1'b0;
    instr_ready     = 1'b0;
    lcg_state       = 16;
    fetch_addr      = 32'd0;
    last_due        = 0;
    cyc             = 0;
    exp_idx         = 0;
    n_checks        = 0;
    n_errors        = 0;
    wd_limit        = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      gold[i] = fill_word(i);
    end
    $readmemh("testbench/albuf_golden.txt", gold);
    err_mask = {gold[MASK_BASE + 1], gold[MASK_BASE]};
    n_tests  = int'(gold[TEST_BASE]);
    total    = 0;
    for (int t = 0; t < n_tests; t++) begin
      total += int'(gold[TEST_BASE + 4 * t + 4]);
    end
    wd_limit = 200 * total + 20;

    repeat (10) @(posedge clk);
    #10;
    rst_n = 1'b1;

    for (int t = 0; t < n_tests; t++) begin
      target    = gold[TEST_BASE + 4 * t + 1];
      kills     = int'(gold[TEST_BASE + 4 * t + 2]);
      pct       = int'(gold[TEST_BASE + 4 * t + 3]);
      n_exp     = int'(gold[TEST_BASE + 4 * t + 4]);
      cur_test  = t;
      exp_start = exp_idx;
      exp_end   = exp_idx + n_exp;
      // Kill held, branch on its last cycle
      for (int k = 0; k < kills; k++) begin
        step(1'b1, k == kills - 1, target, pct);
      end
      while (exp_idx < exp_end) begin
        step(1'b0, 1'b0, 32'd0, pct);
      end
    end

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (wd_limit != 0);
    repeat (wd_limit) @(posedge clk);
    $display("timeout: expected instructions did not arrive within %0d cycles", wd_limit);
    $display("Regression failed");
    $finish;
  end

endmodule
